//--- include/alu_ops_defines.svh
// --------------------
// ALU ops engine sizes
// Widths, buffer depth and credit counts
// --------------------
`ifndef ALU_OPS_DEFINES_SVH
`define ALU_OPS_DEFINES_SVH

// Packet field widths
`define ALU_DATA_W 32
`define ROUTE_W 8
`define ADDR_W 32

// Job descriptor packet count
`define COUNT_W 16

// Input buffer slots, also the credits upstream starts with
`define RESPONSE_DEPTH 8

// Credits held for the downstream side after reset
`define REQUEST_CREDITS 4

// Wide enough for REQUEST_CREDITS
`define CREDIT_W 4

`endif

//--- hw/alu_ops_pkg.sv
// --------------------
// ALU ops types
// Opcode and sequencer state encodings
// --------------------
`default_nettype none

package alu_ops_pkg;

    // Opcodes carried in the config word
    // Code 7 is unassigned and behaves as pass
    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_and  = 3'd2,
        alu_or   = 3'd3,
        alu_xor  = 3'd4,
        alu_pass = 3'd5,
        alu_min  = 3'd6
    } alu_op_t;

    // Job sequencer states
    typedef enum logic [2:0] {
        seq_idle        = 3'd0,
        seq_request     = 3'd1,
        seq_wait_config = 3'd2,
        seq_run         = 3'd3,
        seq_finish      = 3'd4
    } seq_state_t;

endpackage

`default_nettype wire

//--- hw/packet_pkg.sv
// --------------------
// Memory packet types
// Route, address and data fields
// --------------------
`default_nettype none

`include "alu_ops_defines.svh"

package packet_pkg;

    // Source or destination route id
    typedef logic [`ROUTE_W-1:0] route_t;

    // Packet address
    typedef logic [`ADDR_W-1:0] address_t;

    // Data word, also the ALU operand
    typedef logic [`ALU_DATA_W-1:0] data_t;

endpackage

`default_nettype wire

//--- hw/alu_ops_sequencer.sv
// --------------------
// ALU ops sequencer
// Job FSM, config capture and packet count
// --------------------
`default_nettype none

`include "alu_ops_defines.svh"

module alu_ops_sequencer (
    input  wire                     ap_clk,
    input  wire                     areset_generator,
    input  wire                     descriptor_valid,
    input  wire [`COUNT_W-1:0]      descriptor_count,
    input  wire                     config_valid,
    input  wire alu_ops_pkg::alu_op_t config_op,
    input  wire packet_pkg::data_t  config_operand,
    input  wire                     result_fire,
    output logic                    config_request,
    output logic                    param_valid,
    output alu_ops_pkg::alu_op_t    op,
    output packet_pkg::data_t       operand,
    output logic                    done
);

    alu_ops_pkg::seq_state_t state;

    // Results still owed for the current job
    logic [`COUNT_W-1:0] remaining;

    // --------------------
    // Job FSM
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state       <= alu_ops_pkg::seq_idle;
            param_valid <= 1'b0;
            remaining   <= '0;
        end else begin
            case (state)
                alu_ops_pkg::seq_idle: begin
                    // Zero-length jobs never start
                    if (descriptor_valid && (descriptor_count != '0)) begin
                        remaining <= descriptor_count;
                        state     <= alu_ops_pkg::seq_request;
                    end
                end
                alu_ops_pkg::seq_request: begin
                    state <= alu_ops_pkg::seq_wait_config;
                end
                alu_ops_pkg::seq_wait_config: begin
                    if (config_valid) begin
                        param_valid <= 1'b1;
                        state       <= alu_ops_pkg::seq_run;
                    end
                end
                alu_ops_pkg::seq_run: begin
                    if (result_fire) begin
                        remaining <= remaining - `COUNT_W'(1);
                        // Last result of the job leaves this cycle
                        if (remaining == `COUNT_W'(1)) begin
                            param_valid <= 1'b0;
                            state       <= alu_ops_pkg::seq_finish;
                        end
                    end
                end
                alu_ops_pkg::seq_finish: begin
                    state <= alu_ops_pkg::seq_idle;
                end
                default: begin
                    state <= alu_ops_pkg::seq_idle;
                end
            endcase
        end
    end

    // --------------------
    // Config capture
    // --------------------
    // Only the first answer after the request is taken
    always_ff @(posedge ap_clk) begin
        if ((state == alu_ops_pkg::seq_wait_config) && config_valid) begin
            op      <= config_op;
            operand <= config_operand;
        end
    end

    // Single-cycle pulses decoded from state
    assign config_request = (state == alu_ops_pkg::seq_request);
    assign done           = (state == alu_ops_pkg::seq_finish);

endmodule

`default_nettype wire

//--- hw/response_buffer.sv
// --------------------
// Response buffer
// FWFT packet FIFO, returns a credit per pop
// --------------------
`default_nettype none

`include "alu_ops_defines.svh"

module response_buffer (
    input  wire                     ap_clk,
    input  wire                     areset_generator,
    input  wire                     response_valid,
    input  wire packet_pkg::route_t   response_from,
    input  wire packet_pkg::route_t   response_to,
    input  wire packet_pkg::address_t response_address,
    input  wire packet_pkg::data_t    response_data,
    input  wire                     buffer_pop,
    output logic                    buffer_valid,
    output packet_pkg::route_t      buffer_from,
    output packet_pkg::route_t      buffer_to,
    output packet_pkg::address_t    buffer_address,
    output packet_pkg::data_t       buffer_data,
    output logic                    response_credit
);

    // Depth is a power of two so pointers wrap on their own
    localparam int ptr_w = $clog2(`RESPONSE_DEPTH);
    localparam int cnt_w = $clog2(`RESPONSE_DEPTH + 1);

    packet_pkg::route_t   from_mem    [`RESPONSE_DEPTH];
    packet_pkg::route_t   to_mem      [`RESPONSE_DEPTH];
    packet_pkg::address_t address_mem [`RESPONSE_DEPTH];
    packet_pkg::data_t    data_mem    [`RESPONSE_DEPTH];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign buffer_valid = (count != '0);
    assign wr_en        = response_valid && (count != cnt_w'(`RESPONSE_DEPTH));
    assign rd_en        = buffer_pop && buffer_valid;

    // Packet storage
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            from_mem[wr_ptr]    <= response_from;
            to_mem[wr_ptr]      <= response_to;
            address_mem[wr_ptr] <= response_address;
            data_mem[wr_ptr]    <= response_data;
        end
    end

    // Pointers, occupancy and credit return
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            response_credit <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + ptr_w'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + ptr_w'(1);
            end
            count           <= count + cnt_w'(wr_en) - cnt_w'(rd_en);
            response_credit <= rd_en;
        end
    end

    // Head of queue shows without a read
    assign buffer_from    = from_mem[rd_ptr];
    assign buffer_to      = to_mem[rd_ptr];
    assign buffer_address = address_mem[rd_ptr];
    assign buffer_data    = data_mem[rd_ptr];

endmodule

`default_nettype wire

//--- hw/alu_ops_datapath.sv
// --------------------
// ALU ops datapath
// Pops packets, applies the opcode, spends output credits
// --------------------
`default_nettype none

`include "alu_ops_defines.svh"

module alu_ops_datapath (
    input  wire                     ap_clk,
    input  wire                     areset_generator,
    input  wire                     param_valid,
    input  wire alu_ops_pkg::alu_op_t op,
    input  wire packet_pkg::data_t  operand,
    input  wire                     buffer_valid,
    input  wire packet_pkg::route_t   buffer_from,
    input  wire packet_pkg::route_t   buffer_to,
    input  wire packet_pkg::address_t buffer_address,
    input  wire packet_pkg::data_t    buffer_data,
    input  wire                     request_credit,
    output logic                    buffer_pop,
    output logic                    request_valid,
    output packet_pkg::route_t      request_from,
    output packet_pkg::route_t      request_to,
    output packet_pkg::address_t    request_address,
    output packet_pkg::data_t       request_data,
    output logic                    result_fire
);

    logic [`CREDIT_W-1:0] credits;
    packet_pkg::data_t    result;

    // --------------------
    // Output credits
    // --------------------
    // Credit is taken at the pop, so the registered packet already owns one
    assign buffer_pop = param_valid && buffer_valid && (credits != '0);

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            credits <= `CREDIT_W'(`REQUEST_CREDITS);
        end else begin
            case ({buffer_pop, request_credit})
                2'b10:   credits <= credits - `CREDIT_W'(1);
                2'b01:   credits <= credits + `CREDIT_W'(1);
                default: credits <= credits;
            endcase
        end
    end

    // --------------------
    // ALU
    // --------------------
    always_comb begin
        case (op)
            alu_ops_pkg::alu_add: result = buffer_data + operand;
            alu_ops_pkg::alu_sub: result = buffer_data - operand;
            alu_ops_pkg::alu_and: result = buffer_data & operand;
            alu_ops_pkg::alu_or:  result = buffer_data | operand;
            alu_ops_pkg::alu_xor: result = buffer_data ^ operand;
            // Unsigned compare
            alu_ops_pkg::alu_min: result = (buffer_data < operand) ? buffer_data : operand;
            // Pass and the spare code 7
            default:              result = buffer_data;
        endcase
    end

    // --------------------
    // Request register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            request_valid <= 1'b0;
        end else begin
            request_valid <= buffer_pop;
        end
    end

    // Metadata goes through unchanged
    always_ff @(posedge ap_clk) begin
        if (buffer_pop) begin
            request_from    <= buffer_from;
            request_to      <= buffer_to;
            request_address <= buffer_address;
            request_data    <= result;
        end
    end

    assign result_fire = request_valid;

endmodule

`default_nettype wire

//--- hw/alu_ops_engine.sv
// --------------------
// ALU ops engine
// Sequencer, input buffer and datapath
// --------------------
`default_nettype none

`include "alu_ops_defines.svh"

module alu_ops_engine (
    input  wire                     ap_clk,
    input  wire                     areset_generator,
    input  wire                     descriptor_valid,
    input  wire [`COUNT_W-1:0]      descriptor_count,
    input  wire                     config_valid,
    input  wire alu_ops_pkg::alu_op_t config_op,
    input  wire packet_pkg::data_t  config_operand,
    input  wire                     response_valid,
    input  wire packet_pkg::route_t   response_from,
    input  wire packet_pkg::route_t   response_to,
    input  wire packet_pkg::address_t response_address,
    input  wire packet_pkg::data_t    response_data,
    input  wire                     request_credit,
    output logic                    config_request,
    output logic                    response_credit,
    output logic                    request_valid,
    output packet_pkg::route_t      request_from,
    output packet_pkg::route_t      request_to,
    output packet_pkg::address_t    request_address,
    output packet_pkg::data_t       request_data,
    output logic                    done
);

    // Job parameters
    logic                 param_valid;
    alu_ops_pkg::alu_op_t op;
    packet_pkg::data_t    operand;
    logic                 result_fire;

    // Buffer head
    logic                 buffer_valid;
    logic                 buffer_pop;
    packet_pkg::route_t   buffer_from;
    packet_pkg::route_t   buffer_to;
    packet_pkg::address_t buffer_address;
    packet_pkg::data_t    buffer_data;

    alu_ops_sequencer i_alu_ops_sequencer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .descriptor_valid (descriptor_valid),
        .descriptor_count (descriptor_count),
        .config_valid     (config_valid),
        .config_op        (config_op),
        .config_operand   (config_operand),
        .result_fire      (result_fire),
        .config_request   (config_request),
        .param_valid      (param_valid),
        .op               (op),
        .operand          (operand),
        .done             (done)
    );

    response_buffer i_response_buffer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .response_valid   (response_valid),
        .response_from    (response_from),
        .response_to      (response_to),
        .response_address (response_address),
        .response_data    (response_data),
        .buffer_pop       (buffer_pop),
        .buffer_valid     (buffer_valid),
        .buffer_from      (buffer_from),
        .buffer_to        (buffer_to),
        .buffer_address   (buffer_address),
        .buffer_data      (buffer_data),
        .response_credit  (response_credit)
    );

    alu_ops_datapath i_alu_ops_datapath (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .param_valid      (param_valid),
        .op               (op),
        .operand          (operand),
        .buffer_valid     (buffer_valid),
        .buffer_from      (buffer_from),
        .buffer_to        (buffer_to),
        .buffer_address   (buffer_address),
        .buffer_data      (buffer_data),
        .request_credit   (request_credit),
        .buffer_pop       (buffer_pop),
        .request_valid    (request_valid),
        .request_from     (request_from),
        .request_to       (request_to),
        .request_address  (request_address),
        .request_data     (request_data),
        .result_fire      (result_fire)
    );

endmodule

`default_nettype wire

//--- sim/tb_alu_ops_engine.sv
// --------------------
// ALU ops engine testbench
// Runs one job per opcode with credit flow both ways
// --------------------
`default_nettype none

`include "alu_ops_defines.svh"

module tb_alu_ops_engine;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit = 300;

    typedef struct packed {
        packet_pkg::route_t   from_route;
        packet_pkg::route_t   to_route;
        packet_pkg::address_t address;
        packet_pkg::data_t    data;
    } expected_packet_t;

    // DUT inputs
    logic                   ap_clk = 1'b0;
    logic                   areset_generator = 1'b1;
    logic                   descriptor_valid = 1'b0;
    logic [`COUNT_W-1:0]    descriptor_count = '0;
    logic                   config_valid = 1'b0;
    alu_ops_pkg::alu_op_t   config_op = alu_ops_pkg::alu_add;
    packet_pkg::data_t      config_operand = '0;
    logic                   response_valid = 1'b0;
    packet_pkg::route_t     response_from = '0;
    packet_pkg::route_t     response_to = '0;
    packet_pkg::address_t   response_address = '0;
    packet_pkg::data_t      response_data = '0;
    logic                   request_credit = 1'b0;

    // DUT outputs
    wire                    config_request;
    wire                    response_credit;
    wire                    request_valid;
    packet_pkg::route_t     request_from;
    packet_pkg::route_t     request_to;
    packet_pkg::address_t   request_address;
    packet_pkg::data_t      request_data;
    wire                    done;

    // Reference model state
    expected_packet_t expected_q[$];
    integer seed = 32'h480c;
    int     errors = 0;
    int     tests_run = 0;
    int     packets_sent = 0;
    int     job_count = 0;
    logic   quiet_window = 1'b1;
    int     release_cycle = 0;

    // Monitor counters
    int cycle_count = 0;
    int requests_seen = 0;
    int credits_returned = 0;
    int credit_owed = 0;
    int response_credits = 0;
    int config_pulses = 0;
    int done_pulses = 0;
    int job_results = 0;

    alu_ops_engine i_alu_ops_engine (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .descriptor_valid (descriptor_valid),
        .descriptor_count (descriptor_count),
        .config_valid     (config_valid),
        .config_op        (config_op),
        .config_operand   (config_operand),
        .response_valid   (response_valid),
        .response_from    (response_from),
        .response_to      (response_to),
        .response_address (response_address),
        .response_data    (response_data),
        .request_credit   (request_credit),
        .config_request   (config_request),
        .response_credit  (response_credit),
        .request_valid    (request_valid),
        .request_from     (request_from),
        .request_to       (request_to),
        .request_address  (request_address),
        .request_data     (request_data),
        .done             (done)
    );

    always #20 ap_clk = ~ap_clk;

    // Sub is data minus operand, min is unsigned, spare codes pass
    function automatic packet_pkg::data_t expected_result(input logic [2:0] code,
            input packet_pkg::data_t data, input packet_pkg::data_t opnd);
        case (code)
            3'd0:    return data + opnd;
            3'd1:    return data - opnd;
            3'd2:    return data & opnd;
            3'd3:    return data | opnd;
            3'd4:    return data ^ opnd;
            3'd6:    return (data < opnd) ? data : opnd;
            default: return data;
        endcase
    endfunction

    function automatic string op_name(input logic [2:0] code);
        case (code)
            3'd0:    return "add";
            3'd1:    return "sub";
            3'd2:    return "and";
            3'd3:    return "or";
            3'd4:    return "xor";
            3'd5:    return "pass";
            3'd6:    return "min";
            default: return "spare code 7";
        endcase
    endfunction

    // --------------------
    // Concurrent checks
    // --------------------
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        quiet_window |-> !(request_valid || response_credit || config_request || done))
    else begin
        errors++;
        $display("mismatch {request_valid,response_credit,config_request,done} got 0x%0h %s",
            $sampled({request_valid, response_credit, config_request, done}),
            "expected 0x0 before the first descriptor");
    end

    // Requests never outrun the credits granted downstream
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        requests_seen <= `REQUEST_CREDITS + credits_returned)
    else begin
        errors++;
        $display("mismatch request_valid count 0x%0h above credit limit 0x%0h",
            requests_seen, `REQUEST_CREDITS + credits_returned);
    end

    task automatic check_request();
        expected_packet_t exp_pkt;
        if (expected_q.size() == 0) begin
            errors++;
            $display("request_valid seen with no response packet outstanding");
        end else begin
            exp_pkt = expected_q.pop_front();
            assert (request_from == exp_pkt.from_route) else begin
                errors++;
                $display("mismatch request_from got 0x%0h expected 0x%0h",
                    request_from, exp_pkt.from_route);
            end
            assert (request_to == exp_pkt.to_route) else begin
                errors++;
                $display("mismatch request_to got 0x%0h expected 0x%0h",
                    request_to, exp_pkt.to_route);
            end
            assert (request_address == exp_pkt.address) else begin
                errors++;
                $display("mismatch request_address got 0x%0h expected 0x%0h",
                    request_address, exp_pkt.address);
            end
            assert (request_data == exp_pkt.data) else begin
                errors++;
                $display("mismatch request_data got 0x%0h expected 0x%0h",
                    request_data, exp_pkt.data);
            end
        end
    endtask

    // --------------------
    // Output monitor and downstream model
    // --------------------
    always @(negedge ap_clk) begin : monitor
        int owed_now;
        cycle_count <= cycle_count + 1;
        if (!areset_generator) begin
            owed_now = credit_owed + (request_valid ? 1 : 0);
            if (request_valid) begin
                check_request();
                requests_seen <= requests_seen + 1;
            end
            if (response_credit) begin
                response_credits <= response_credits + 1;
            end
            if (config_request) begin
                assert (done_pulses == config_pulses) else begin
                    errors++;
                    $display("config_request arrived before the previous job finished");
                end
                config_pulses <= config_pulses + 1;
            end
            if (done) begin
                assert (job_results == job_count) else begin
                    errors++;
                    $display("mismatch job_results got 0x%0h expected 0x%0h",
                        job_results, job_count);
                end
                assert (config_pulses == done_pulses + 1) else begin
                    errors++;
                    $display("done pulsed without a matching config_request");
                end
                done_pulses <= done_pulses + 1;
            end
            job_results <= done ? 0 : job_results + (request_valid ? 1 : 0);
            // Credits come back one per cycle once released
            if ((cycle_count >= release_cycle) && (owed_now > 0)) begin
                request_credit   <= 1'b1;
                credits_returned <= credits_returned + 1;
                credit_owed      <= owed_now - 1;
            end else begin
                request_credit <= 1'b0;
                credit_owed    <= owed_now;
            end
        end
    end

    task automatic print_summary();
        $display("tests %0d, packets %0d, requests %0d, errors %0d",
            tests_run, packets_sent, requests_seen, errors);
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        print_summary();
        $display("Simulation failed");
        $finish;
    endtask

    task automatic wait_for_config_request();
        int cycles;
        cycles = 0;
        while (!config_request) begin
            @(negedge ap_clk);
            cycles++;
            if (cycles > wait_limit) begin
                abort_run("config_request never pulsed after the descriptor");
            end
        end
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (!done) begin
            @(negedge ap_clk);
            cycles++;
            if (cycles > wait_limit) begin
                abort_run("done never pulsed after the last packet");
            end
        end
    endtask

    // Upstream sends one packet per cycle while it holds a credit
    task automatic send_packets(input logic [2:0] code, input packet_pkg::data_t opnd,
            input int count);
        expected_packet_t pkt;
        logic [31:0]      rand_word;
        int               sent;
        int               stalled;
        sent = 0;
        stalled = 0;
        while (sent < count) begin
            @(negedge ap_clk);
            if (packets_sent < `RESPONSE_DEPTH + response_credits) begin
                rand_word      = $random(seed);
                pkt.from_route = rand_word[`ROUTE_W-1:0];
                pkt.to_route   = rand_word[2*`ROUTE_W-1:`ROUTE_W];
                pkt.address    = $random(seed);
                pkt.data       = $random(seed);
                response_valid   <= 1'b1;
                response_from    <= pkt.from_route;
                response_to      <= pkt.to_route;
                response_address <= pkt.address;
                response_data    <= pkt.data;
                pkt.data = expected_result(code, pkt.data, opnd);
                expected_q.push_back(pkt);
                packets_sent++;
                sent++;
                stalled = 0;
            end else begin
                response_valid <= 1'b0;
                stalled++;
                if (stalled > wait_limit) begin
                    abort_run("no upstream credit came back from response_credit");
                end
            end
        end
        @(negedge ap_clk);
        response_valid <= 1'b0;
    endtask

    task automatic run_job(input logic [2:0] code, input int count, input int hold);
        packet_pkg::data_t opnd;
        int                errors_before;
        errors_before = errors;
        opnd = $random(seed);
        job_count = count;
        @(negedge ap_clk);
        quiet_window     <= 1'b0;
        release_cycle    <= cycle_count + hold;
        descriptor_valid <= 1'b1;
        descriptor_count <= `COUNT_W'(count);
        @(negedge ap_clk);
        descriptor_valid <= 1'b0;
        wait_for_config_request();
        repeat (2) @(negedge ap_clk);
        config_valid   <= 1'b1;
        config_op      <= alu_ops_pkg::alu_op_t'(code);
        config_operand <= opnd;
        @(negedge ap_clk);
        config_valid <= 1'b0;
        send_packets(code, opnd, count);
        wait_for_done();
        @(negedge ap_clk);
        tests_run++;
        $display("test %s: %0d packets, %0d errors", op_name(code), count,
            errors - errors_before);
    endtask

    task automatic check_totals();
        int errors_before;
        errors_before = errors;
        assert (response_credits == packets_sent) else begin
            errors++;
            $display("mismatch response_credit pulses got 0x%0h expected 0x%0h",
                response_credits, packets_sent);
        end
        assert ((requests_seen == packets_sent) && (expected_q.size() == 0)) else begin
            errors++;
            $display("mismatch request_valid count got 0x%0h expected 0x%0h",
                requests_seen, packets_sent);
        end
        assert ((config_pulses == 8) && (done_pulses == 8)) else begin
            errors++;
            $display("mismatch config_request 0x%0h done 0x%0h expected 0x8 each",
                config_pulses, done_pulses);
        end
        tests_run++;
        $display("test totals: %0d errors", errors - errors_before);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        repeat (4) @(negedge ap_clk);
        areset_generator <= 1'b0;
        repeat (10) @(negedge ap_clk);
        tests_run++;
        $display("test idle after reset: %0d errors", errors);
        for (int code = 0; code < 8; code++) begin
            // The or job runs long with credits held back for a while
            if (code == 3) begin
                run_job(3'(code), 14, 60);
            end else begin
                run_job(3'(code), 6, 0);
            end
        end
        repeat (4) @(negedge ap_clk);
        check_totals();
        print_summary();
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
hw/alu_ops_pkg.sv
hw/packet_pkg.sv
hw/alu_ops_sequencer.sv
hw/response_buffer.sv
hw/alu_ops_datapath.sv
hw/alu_ops_engine.sv
sim/tb_alu_ops_engine.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the ALU ops engine testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
top=tb_alu_ops_engine

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module "$top" -Mdir "$build_dir" -o "$top"
if [ $? -ne 0 ]; then
    echo "Verilator compile step returned an error"
    exit 1
fi

"./$build_dir/$top" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" "$log_file"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi
